/* project.f */
common/systolic_pkg.sv
logic/stream_skid_buffer.sv
processing_element/pe_accumulator.sv
processing_element/pe_control_unit.sv
processing_element/processing_element.sv
logic/systolic_array.sv
verification/result_checker.sv
verification/systolic_array_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the systolic array testbench with Verilator
set -u -o pipefail

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal -f project.f \
  --top-module systolic_array_tb --Mdir "$build_dir" -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_bin" | tee "$log_file"
if [ $? -ne 0 ]; then
  echo "Simulation did not run to completion"
  exit 1
fi

if grep -q "Test failed" "$log_file"; then
  exit 1
fi
if ! grep -q "Test passed" "$log_file"; then
  echo "No result line found in $log_file"
  exit 1
fi
exit 0

/* verification/systolic_array_tb.sv */
`timescale 1ns/1ps

module systolic_array_tb;

  localparam int rows = systolic_pkg::array_rows;
  localparam int cols = systolic_pkg::array_cols;
  localparam int max_len = 8;
  localparam int max_batch = 4;
  // Watchdog budget per operand word, plus fixed slack
  localparam int cycles_per_word = 40;
  localparam int margin = 200;

  logic clk;
  logic rst;
  systolic_pkg::left_word_t [rows-1:0] left_word;
  logic [rows-1:0] left_valid;
  logic [rows-1:0] left_ready;
  systolic_pkg::vert_word_t [cols-1:0] up_word;
  logic [cols-1:0] up_valid;
  logic [cols-1:0] up_ready;
  systolic_pkg::vert_word_t [cols-1:0] down_word;
  logic [cols-1:0] down_valid;
  logic [cols-1:0] down_ready;
  logic err_unaligned;
  logic err_tag;

  integer seed;
  int total_len = 0;
  logic stall_mode;
  // Cuts row 0 one word short, last mark one word early
  logic short_row;

  // Matrices streamed back to back by one send
  systolic_pkg::operand_t [rows-1:0][max_len-1:0] batch_a [max_batch];
  systolic_pkg::operand_t [max_len-1:0][cols-1:0] batch_b [max_batch];
  int batch_len [max_batch];
  int batch_size;

  systolic_array systolic_array_i (
    .clk(clk),
    .rst(rst),
    .left_word(left_word),
    .left_valid(left_valid),
    .left_ready(left_ready),
    .up_word(up_word),
    .up_valid(up_valid),
    .up_ready(up_ready),
    .down_word(down_word),
    .down_valid(down_valid),
    .down_ready(down_ready),
    .err_unaligned(err_unaligned),
    .err_tag(err_tag)
  );

  result_checker result_checker_i (
    .clk(clk),
    .rst(rst),
    .down_word(down_word),
    .down_valid(down_valid),
    .down_ready(down_ready),
    .err_unaligned(err_unaligned),
    .err_tag(err_tag)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Random bottom back-pressure on both columns
  always @(posedge clk) begin
    if (stall_mode) begin
      down_ready <= cols'($random(seed));
    end else begin
      down_ready <= '1;
    end
  end

  task automatic send_row(int r);
    int n;
    for (int m = 0; m < batch_size; m++) begin
      n = (short_row && r == 0) ? batch_len[m] - 1 : batch_len[m];
      for (int k = 0; k < n; k++) begin
        left_word[r] <= systolic_pkg::left_word_t'{data: batch_a[m][r][k], last: k == n - 1};
        left_valid[r] <= 1'b1;
        do @(posedge clk); while (!left_ready[r]);
      end
    end
    left_valid[r] <= 1'b0;
  endtask

  task automatic send_col(int c);
    for (int m = 0; m < batch_size; m++) begin
      for (int k = 0; k < batch_len[m]; k++) begin
        up_word[c] <= systolic_pkg::vert_word_t'{data: batch_b[m][k][c],
                                                 last: k == batch_len[m] - 1,
                                                 kind: systolic_pkg::kind_operand,
                                                 spare: '0, row: '0};
        up_valid[c] <= 1'b1;
        do @(posedge clk); while (!up_ready[c]);
      end
    end
    up_valid[c] <= 1'b0;
  endtask

  // All four edge streams run concurrently
  task automatic send_batch();
    @(posedge clk);
    fork
      send_row(0);
      send_row(1);
      send_col(0);
      send_col(1);
    join
  endtask

  function automatic int random_len();
    return 2 + int'($unsigned($random(seed)) % 7);
  endfunction

  task automatic make_random(int m, int len);
    batch_len[m] = len;
    batch_a[m] = '0;
    batch_b[m] = '0;
    for (int k = 0; k < len; k++) begin
      for (int r = 0; r < rows; r++) begin
        batch_a[m][r][k] = systolic_pkg::operand_t'($random(seed));
      end
      for (int c = 0; c < cols; c++) begin
        batch_b[m][k][c] = systolic_pkg::operand_t'($random(seed));
      end
    end
  endtask

  // Log first so the checker knows every burst before it arrives
  task automatic run_batch(string name);
    for (int m = 0; m < batch_size; m++) begin
      result_checker_i.log_matrix(name, batch_a[m], batch_b[m], batch_len[m]);
      total_len += batch_len[m];
    end
    send_batch();
    while (!result_checker_i.all_received()) @(posedge clk);
  endtask

  initial begin : main_sequence
    int wait_cycles;
    seed = 86;
    rst = 1'b1;
    left_word = '0;
    left_valid = '0;
    up_word = '0;
    up_valid = '0;
    down_ready = '1;
    stall_mode = 1'b0;
    short_row = 1'b0;
    batch_size = 1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // A column 1.0 and -2.0, B row 1.5 and -0.25
    batch_len[0] = 1;
    batch_a[0] = '0;
    batch_b[0] = '0;
    batch_a[0][0][0] = 16'sh1000;
    batch_a[0][1][0] = 16'she000;
    batch_b[0][0][0] = 16'sh1800;
    batch_b[0][0][1] = 16'shfc00;
    run_batch("single_product");
    result_checker_i.check_unaligned("single_product", 1'b0);
    result_checker_i.check_tag("single_product", 1'b0);
    result_checker_i.end_test("single_product");

    for (int i = 0; i < 5; i++) begin
      make_random(0, random_len());
      run_batch("random_vectors");
    end
    result_checker_i.check_unaligned("random_vectors", 1'b0);
    result_checker_i.check_tag("random_vectors", 1'b0);
    result_checker_i.end_test("random_vectors");

    // Second matrix follows on the same streams with no gap
    batch_size = 2;
    make_random(0, random_len());
    make_random(1, random_len());
    run_batch("back_to_back");
    result_checker_i.check_unaligned("back_to_back", 1'b0);
    result_checker_i.check_tag("back_to_back", 1'b0);
    result_checker_i.end_test("back_to_back");

    batch_size = 3;
    for (int m = 0; m < 3; m++) begin
      make_random(m, random_len());
    end
    @(posedge clk);
    stall_mode <= 1'b1;
    run_batch("output_stalls");
    stall_mode <= 1'b0;
    @(posedge clk);
    result_checker_i.check_unaligned("output_stalls", 1'b0);
    result_checker_i.check_tag("output_stalls", 1'b0);
    result_checker_i.end_test("output_stalls");

    // Broken row stream, outputs ignored until reset
    batch_size = 1;
    make_random(0, 3);
    short_row = 1'b1;
    total_len += 3;
    result_checker_i.set_discard(1'b1);
    send_batch();
    wait_cycles = 0;
    while (!err_unaligned && wait_cycles < cycles_per_word * 3) begin
      @(posedge clk);
      wait_cycles++;
    end
    result_checker_i.check_unaligned("misaligned_last", 1'b1);
    // Flag must hold without a reset
    repeat (10) @(posedge clk);
    result_checker_i.check_unaligned("misaligned_last", 1'b1);
    rst <= 1'b1;
    short_row = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    result_checker_i.set_discard(1'b0);
    result_checker_i.check_unaligned("misaligned_last", 1'b0);
    result_checker_i.check_tag("misaligned_last", 1'b0);
    make_random(0, 4);
    run_batch("misaligned_last");
    result_checker_i.check_unaligned("misaligned_last", 1'b0);
    result_checker_i.check_tag("misaligned_last", 1'b0);
    result_checker_i.end_test("misaligned_last");

    $display("tests %0d, checks %0d, errors %0d", result_checker_i.test_count,
             result_checker_i.check_count, result_checker_i.error_count);
    if (result_checker_i.error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Budget grows with every matrix logged
  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count <= cycles_per_word * total_len + margin) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, results still missing", cycle_count);
    $display("Test failed");
    $finish;
  end

endmodule

/* verification/result_checker.sv */
`timescale 1ns/1ps

module result_checker (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  systolic_pkg::vert_word_t [systolic_pkg::array_cols-1:0] down_word,
  input  logic [systolic_pkg::array_cols-1:0]                   down_valid,
  input  logic [systolic_pkg::array_cols-1:0]                   down_ready,
  input  logic                                                  err_unaligned,
  input  logic                                                  err_tag
);

  localparam int rows = systolic_pkg::array_rows;
  localparam int cols = systolic_pkg::array_cols;
  localparam int max_len = 8;

  typedef systolic_pkg::operand_t [rows-1:0][max_len-1:0] a_mat_t;
  typedef systolic_pkg::operand_t [max_len-1:0][cols-1:0] b_mat_t;

  // Every matrix sent, in order, with its test name
  a_mat_t a_log [$];
  b_mat_t b_log [$];
  int len_log [$];
  string name_log [$];

  // Per column: matrix being received and word position in its burst
  int col_idx [cols];
  int col_pos [cols];

  bit discard = 1'b0;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int test_errors = 0;

  // Exact sum of products, floor divided by 2^frac_bits, kept to 16 bits
  function automatic systolic_pkg::operand_t expected_element(a_mat_t a, b_mat_t b, int len,
                                                             int r, int c);
    longint sum;
    systolic_pkg::operand_t x;
    systolic_pkg::operand_t y;
    sum = 0;
    for (int k = 0; k < len; k++) begin
      x = a[r][k];
      y = b[k][c];
      sum += longint'(x) * longint'(y);
    end
    return systolic_pkg::operand_t'(sum >>> systolic_pkg::frac_bits);
  endfunction

  // Burst runs bottom row first, last mark on row 0
  function automatic systolic_pkg::vert_word_t expected_word(int idx, int pos, int c);
    systolic_pkg::vert_word_t w;
    int r;
    r = rows - 1 - pos;
    w.data = expected_element(a_log[idx], b_log[idx], len_log[idx], r, c);
    w.last = r == 0;
    w.kind = systolic_pkg::kind_result;
    w.spare = '0;
    w.row = systolic_pkg::row_idx_t'(r);
    return w;
  endfunction

  task automatic count_error();
    error_count++;
    test_errors++;
  endtask

  task automatic log_matrix(string name, a_mat_t a, b_mat_t b, int len);
    name_log.push_back(name);
    a_log.push_back(a);
    b_log.push_back(b);
    len_log.push_back(len);
  endtask

  function automatic bit all_received();
    for (int c = 0; c < cols; c++) begin
      if (col_idx[c] != a_log.size()) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Outputs of a deliberately broken stream are not compared
  task automatic set_discard(bit on);
    discard = on;
  endtask

  task automatic end_test(string name);
    test_count++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic check_unaligned(string name, logic expected);
    check_count++;
    if (err_unaligned !== expected) begin
      $display("mismatch %s err_unaligned: expected %b actual %b", name, expected, err_unaligned);
      count_error();
    end
  endtask

  task automatic check_tag(string name, logic expected);
    check_count++;
    if (err_tag !== expected) begin
      $display("mismatch %s err_tag: expected %b actual %b", name, expected, err_tag);
      count_error();
    end
  endtask

  initial begin
    for (int c = 0; c < cols; c++) begin
      col_idx[c] = 0;
      col_pos[c] = 0;
    end
  end

  // One compare per accepted bottom word
  always @(posedge clk) begin : compare
    systolic_pkg::vert_word_t exp_word;
    if (!rst && !discard) begin
      for (int c = 0; c < cols; c++) begin
        if (down_valid[c] && down_ready[c]) begin
          if (col_idx[c] >= a_log.size()) begin
            $display("column %0d sent a result word while no matrix was pending", c);
            count_error();
          end else begin
            exp_word = expected_word(col_idx[c], col_pos[c], c);
            check_count++;
            if (down_word[c] !== exp_word) begin
              $display("mismatch %s col %0d word %0d: expected %h actual %h",
                       name_log[col_idx[c]], c, col_pos[c], exp_word, down_word[c]);
              count_error();
            end
            col_pos[c]++;
            // Burst complete, move to the next matrix
            if (col_pos[c] == rows) begin
              col_pos[c] = 0;
              col_idx[c]++;
            end
          end
        end
      end
    end
  end

endmodule

/* logic/systolic_array.sv */
`timescale 1ns/1ps

module systolic_array (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  systolic_pkg::left_word_t [systolic_pkg::array_rows-1:0] left_word,
  input  logic [systolic_pkg::array_rows-1:0]                   left_valid,
  output logic [systolic_pkg::array_rows-1:0]                   left_ready,
  input  systolic_pkg::vert_word_t [systolic_pkg::array_cols-1:0] up_word,
  input  logic [systolic_pkg::array_cols-1:0]                   up_valid,
  output logic [systolic_pkg::array_cols-1:0]                   up_ready,
  output systolic_pkg::vert_word_t [systolic_pkg::array_cols-1:0] down_word,
  output logic [systolic_pkg::array_cols-1:0]                   down_valid,
  input  logic [systolic_pkg::array_cols-1:0]                   down_ready,
  output logic                                                  err_unaligned,
  output logic                                                  err_tag
);

  localparam int rows = systolic_pkg::array_rows;
  localparam int cols = systolic_pkg::array_cols;

  // Horizontal links, column index is the receiving element, cols is the right edge
  systolic_pkg::left_word_t h_word [rows][cols+1];
  logic h_valid [rows][cols+1];
  logic h_ready [rows][cols+1];

  // Vertical links, row index is the receiving element, rows is the bottom edge
  systolic_pkg::vert_word_t v_word [rows+1][cols];
  logic v_valid [rows+1][cols];
  logic v_ready [rows+1][cols];

  logic [rows*cols-1:0] pe_err_unaligned;
  logic [rows*cols-1:0] pe_err_tag;

  genvar r, c;
  generate
    for (r = 0; r < rows; r++) begin : g_row
      // Left edge feeds column 0
      assign h_word[r][0] = left_word[r];
      assign h_valid[r][0] = left_valid[r];
      assign left_ready[r] = h_ready[r][0];
      // Last column never forwards right
      assign h_ready[r][cols] = 1'b1;
    end

    for (c = 0; c < cols; c++) begin : g_col
      assign v_word[0][c] = up_word[c];
      assign v_valid[0][c] = up_valid[c];
      assign up_ready[c] = v_ready[0][c];
      // Bottom edge carries each column's result burst
      assign down_word[c] = v_word[rows][c];
      assign down_valid[c] = v_valid[rows][c];
      assign v_ready[rows][c] = down_ready[c];
    end

    for (r = 0; r < rows; r++) begin : g_pe_row
      for (c = 0; c < cols; c++) begin : g_pe_col
        processing_element #(
          .row_index(r),
          .col_index(c)
        ) pe_i (
          .clk(clk),
          .rst(rst),
          .left_in(h_word[r][c]),
          .left_in_valid(h_valid[r][c]),
          .left_in_ready(h_ready[r][c]),
          .up_in(v_word[r][c]),
          .up_in_valid(v_valid[r][c]),
          .up_in_ready(v_ready[r][c]),
          .right_out(h_word[r][c+1]),
          .right_out_valid(h_valid[r][c+1]),
          .right_out_ready(h_ready[r][c+1]),
          .down_out(v_word[r+1][c]),
          .down_out_valid(v_valid[r+1][c]),
          .down_out_ready(v_ready[r+1][c]),
          .err_unaligned(pe_err_unaligned[r*cols+c]),
          .err_tag(pe_err_tag[r*cols+c])
        );
      end
    end
  endgenerate

  // Any element fault shows at the top
  assign err_unaligned = |pe_err_unaligned;
  assign err_tag = |pe_err_tag;

endmodule

/* processing_element/processing_element.sv */
`timescale 1ns/1ps

module processing_element #(
  parameter int row_index = 0,
  parameter int col_index = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  systolic_pkg::left_word_t left_in,
  input  logic                     left_in_valid,
  output logic                     left_in_ready,
  input  systolic_pkg::vert_word_t up_in,
  input  logic                     up_in_valid,
  output logic                     up_in_ready,
  output systolic_pkg::left_word_t right_out,
  output logic                     right_out_valid,
  input  logic                     right_out_ready,
  output systolic_pkg::vert_word_t down_out,
  output logic                     down_out_valid,
  input  logic                     down_out_ready,
  output logic                     err_unaligned,
  output logic                     err_tag
);

  // Edge position decides which outputs are dropped
  localparam bit last_column = col_index == systolic_pkg::array_cols - 1;
  localparam bit last_row = row_index == systolic_pkg::array_rows - 1;

  systolic_pkg::left_word_t left_buf;
  logic left_buf_valid;
  systolic_pkg::vert_word_t up_buf;
  logic up_buf_valid;
  systolic_pkg::vert_word_t result_word;
  systolic_pkg::operand_t result;
  logic left_take;
  logic up_take;
  logic accumulate;
  logic restart;
  logic send_result;

  // Input registers
  stream_skid_buffer #(
    .word_type(systolic_pkg::left_word_t)
  ) left_skid_i (
    .clk(clk),
    .rst(rst),
    .in_word(left_in),
    .in_valid(left_in_valid),
    .in_ready(left_in_ready),
    .out_word(left_buf),
    .out_valid(left_buf_valid),
    .out_ready(left_take)
  );

  stream_skid_buffer #(
    .word_type(systolic_pkg::vert_word_t)
  ) up_skid_i (
    .clk(clk),
    .rst(rst),
    .in_word(up_in),
    .in_valid(up_in_valid),
    .in_ready(up_in_ready),
    .out_word(up_buf),
    .out_valid(up_buf_valid),
    .out_ready(up_take)
  );

  // A from the left, B from the top
  pe_accumulator accumulator_i (
    .clk(clk),
    .rst(rst),
    .operand_a(left_buf.data),
    .operand_b(up_buf.data),
    .accumulate(accumulate),
    .restart(restart),
    .result(result)
  );

  pe_control_unit #(
    .row_index(row_index),
    .last_column(last_column),
    .last_row(last_row)
  ) control_i (
    .clk(clk),
    .rst(rst),
    .left_valid(left_buf_valid),
    .left_last(left_buf.last),
    .up_valid(up_buf_valid),
    .up_last(up_buf.last),
    .up_kind(up_buf.kind),
    .right_ready(right_out_ready),
    .down_ready(down_out_ready),
    .left_take(left_take),
    .up_take(up_take),
    .accumulate(accumulate),
    .restart(restart),
    .right_valid(right_out_valid),
    .down_valid(down_out_valid),
    .send_result(send_result),
    .err_unaligned(err_unaligned),
    .err_tag(err_tag)
  );

  // Own result, tagged with the row, last only on the top row
  always_comb begin
    result_word.data = result;
    result_word.last = row_index == 0;
    result_word.kind = systolic_pkg::kind_result;
    result_word.spare = '0;
    result_word.row = systolic_pkg::row_idx_t'(row_index);
  end

  // Operands pass through unchanged
  assign right_out = left_buf;
  assign down_out = send_result ? result_word : up_buf;

endmodule

/* processing_element/pe_control_unit.sv */
`timescale 1ns/1ps

module pe_control_unit #(
  parameter int row_index = 0,
  parameter bit last_column = 1'b0,
  parameter bit last_row = 1'b0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     left_valid,
  input  logic                     left_last,
  input  logic                     up_valid,
  input  logic                     up_last,
  input  systolic_pkg::word_kind_t up_kind,
  input  logic                     right_ready,
  input  logic                     down_ready,
  output logic                     left_take,
  output logic                     up_take,
  output logic                     accumulate,
  output logic                     restart,
  output logic                     right_valid,
  output logic                     down_valid,
  output logic                     send_result,
  output logic                     err_unaligned,
  output logic                     err_tag
);

  systolic_pkg::pe_state_t state;
  systolic_pkg::row_idx_t relay_count;
  logic first_pair;
  // Per-output flags for a pair already handed on
  logic right_sent;
  logic down_sent;
  logic pair_valid;
  logic right_done;
  logic down_done;
  logic consume;
  logic export_move;
  logic relay_move;
  logic relay_end;
  logic tag_bad;

  // Both operands present while computing
  assign pair_valid = (state == systolic_pkg::pe_compute) && left_valid && up_valid;

  // Edge outputs count as always satisfied
  assign right_done = last_column || right_sent || right_ready;
  assign down_done = last_row || down_sent || down_ready;
  assign consume = pair_valid && right_done && down_done;

  assign export_move = (state == systolic_pkg::pe_export) && down_ready;
  assign relay_move = (state == systolic_pkg::pe_relay) && up_valid && down_ready;
  assign relay_end = relay_count == systolic_pkg::row_idx_t'(row_index - 1);

  // Both inputs leave together
  assign left_take = consume;
  assign up_take = consume || relay_move;
  assign accumulate = consume;
  assign restart = first_pair;
  assign send_result = state == systolic_pkg::pe_export;

  assign right_valid = pair_valid && !last_column && !right_sent;

  always_comb begin
    case (state)
      systolic_pkg::pe_compute: down_valid = pair_valid && !last_row && !down_sent;
      systolic_pkg::pe_export:  down_valid = 1'b1;
      systolic_pkg::pe_relay:   down_valid = up_valid;
      default:                  down_valid = 1'b0;
    endcase
  end

  // Results from above during compute, operands during relay
  assign tag_bad = up_valid &&
      ((state == systolic_pkg::pe_compute && up_kind == systolic_pkg::kind_result) ||
       (state == systolic_pkg::pe_relay && up_kind == systolic_pkg::kind_operand));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= systolic_pkg::pe_compute;
      relay_count <= '0;
      first_pair <= 1'b1;
      right_sent <= 1'b0;
      down_sent <= 1'b0;
      err_unaligned <= 1'b0;
      err_tag <= 1'b0;
    end else begin
      // Partial forwarding, remember which side already took the pair
      if (consume) begin
        right_sent <= 1'b0;
        down_sent <= 1'b0;
      end else if (pair_valid) begin
        right_sent <= right_sent || (right_valid && right_ready);
        down_sent <= down_sent || (down_valid && down_ready);
      end

      if (consume) begin
        first_pair <= 1'b0;
      end else if (export_move) begin
        first_pair <= 1'b1;
      end

      case (state)
        systolic_pkg::pe_compute: begin
          // Either last mark closes the vector
          if (consume && (left_last || up_last)) begin
            state <= systolic_pkg::pe_export;
          end
        end
        systolic_pkg::pe_export: begin
          if (export_move) begin
            relay_count <= '0;
            // Row 0 has nobody above to relay
            state <= (row_index == 0) ? systolic_pkg::pe_compute : systolic_pkg::pe_relay;
          end
        end
        systolic_pkg::pe_relay: begin
          if (relay_move) begin
            if (relay_end) begin
              state <= systolic_pkg::pe_compute;
            end else begin
              relay_count <= relay_count + 1'b1;
            end
          end
        end
        default: state <= systolic_pkg::pe_compute;
      endcase

      // Sticky until reset
      if (consume && (left_last != up_last)) begin
        err_unaligned <= 1'b1;
      end
      if (tag_bad) begin
        err_tag <= 1'b1;
      end
    end
  end

endmodule

/* processing_element/pe_accumulator.sv */
`timescale 1ns/1ps

module pe_accumulator (
  input  logic                  clk,
  input  logic                  rst,
  input  systolic_pkg::operand_t operand_a,
  input  systolic_pkg::operand_t operand_b,
  input  logic                  accumulate,
  input  logic                  restart,
  output systolic_pkg::operand_t result
);

  systolic_pkg::acc_t sum;
  systolic_pkg::acc_t product;
  systolic_pkg::acc_t base;

  // Operands sign extended to full width before multiply
  assign product = operand_a * operand_b;

  // New vector starts from zero
  assign base = restart ? '0 : sum;

  always_ff @(posedge clk) begin
    if (rst) begin
      sum <= '0;
    end else if (accumulate) begin
      // Wraps on overflow
      sum <= base + product;
    end
  end

  // Q8.24 sum back to Q4.12, floor and wrap
  assign result = sum[systolic_pkg::frac_bits +: systolic_pkg::data_width];

endmodule

/* logic/stream_skid_buffer.sv */
`timescale 1ns/1ps

module stream_skid_buffer #(
  parameter type word_type = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  word_type in_word,
  input  logic     in_valid,
  output logic     in_ready,
  output word_type out_word,
  output logic     out_valid,
  input  logic     out_ready
);

  // Second slot catches a word when the output stalls
  word_type skid_word;
  logic skid_valid;
  logic out_free;

  // Output slot can load when empty or being drained
  assign out_free = out_ready || !out_valid;

  // Ready comes straight from a flop
  assign in_ready = !skid_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // Skid word goes first, else take the new input
      out_valid <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      // Output stuck, park the incoming word
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_word <= skid_valid ? skid_word : in_word;
    end
    // Only meaningful once skid_valid rises
    if (in_ready) begin
      skid_word <= in_word;
    end
  end

endmodule

/* common/systolic_pkg.sv */
package systolic_pkg;

  // Operand and result words, signed Q4.12
  localparam int data_width = 16;
  localparam int frac_bits = 12;

  // 32-bit product plus guard bits for long vectors
  localparam int acc_width = 40;

  // Grid size
  localparam int array_rows = 2;
  localparam int array_cols = 2;
  localparam int row_idx_width = 1;

  // Vertical user tag is kind bit, spare bits, row index
  localparam int tag_width = 4;
  localparam int spare_width = tag_width - 1 - row_idx_width;

  typedef logic signed [data_width-1:0] operand_t;
  typedef logic signed [acc_width-1:0] acc_t;
  typedef logic [row_idx_width-1:0] row_idx_t;
  typedef logic [spare_width-1:0] spare_t;

  // Meaning of the kind bit in the tag
  typedef enum logic {
    kind_operand = 1'b0,
    kind_result = 1'b1
  } word_kind_t;

  // Left-to-right link, A operands
  typedef struct packed {
    operand_t data;
    logic last;
  } left_word_t;

  // Top-to-bottom link, B operands or tagged results
  typedef struct packed {
    operand_t data;
    logic last;
    word_kind_t kind;
    spare_t spare;
    row_idx_t row;
  } vert_word_t;

  // Element control phases
  typedef enum logic [1:0] {
    pe_compute,
    pe_export,
    pe_relay
  } pe_state_t;

endpackage
